// ==== verilog/rx_reg_pkg.sv ====
`default_nettype none

package rx_reg_pkg;

  // **************************************************
  // register map
  // **************************************************

  typedef logic [13:0] reg_addr_t;

  localparam reg_addr_t addr_version = 14'h000;
  localparam reg_addr_t addr_id      = 14'h001;
  localparam reg_addr_t addr_scratch = 14'h002;
  localparam reg_addr_t addr_status  = 14'h010;

  localparam logic [31:0] version_value = 32'h00010000;

  // channel windows, one per channel
  localparam reg_addr_t chan_base   = 14'h100;
  localparam reg_addr_t chan_stride = 14'h010;

  localparam logic [3:0] chan_ctrl_off  = 4'd0;
  localparam logic [3:0] chan_scale_off = 4'd1;

  // offsets carried to the result block for common registers
  localparam logic [3:0] com_version_off  = 4'd0;
  localparam logic [3:0] com_id_off       = 4'd1;
  localparam logic [3:0] com_scratch_off  = 4'd2;
  localparam logic [3:0] com_status_off   = 4'd3;
  localparam logic [3:0] com_unmapped_off = 4'hf;

  // **************************************************
  // register words
  // **************************************************

  typedef struct packed {
    logic [28:0] pad;
    logic        scale_en;
    logic        format_en;
    logic        enable;
  } chan_ctrl_t;

  // coefficient in Q2.14, 0x4000 is unity
  typedef struct packed {
    logic [15:0]        pad;
    logic signed [15:0] coef;
  } chan_scale_t;

  typedef union packed {
    chan_ctrl_t  ctrl;
    chan_scale_t scale;
  } reg_word_u;

  typedef enum logic [1:0] {
    target_common,
    target_ch0,
    target_ch1
  } access_target_e;

  typedef struct packed {
    logic           wr;
    logic           rd;
    access_target_e target;
    logic [3:0]     offset;
    reg_word_u      wdata;
  } up_access_t;

endpackage

`default_nettype wire

// ==== verilog/rx_data_pkg.sv ====
`default_nettype none

package rx_data_pkg;

  // **************************************************
  // sample widths
  // **************************************************

  // raw converter sample, offset binary
  localparam int adc_width = 12;

  // dma side sample
  localparam int out_width = 16;

  // **************************************************
  // sample structs
  // **************************************************

  // i sits in the low half of the adc word
  typedef struct packed {
    logic [adc_width-1:0] q;
    logic [adc_width-1:0] i;
  } adc_raw_t;

  typedef struct packed {
    logic                 enable;
    logic                 valid;
    logic [out_width-1:0] data;
  } chan_out_t;

endpackage

`default_nettype wire

// ==== verilog/rx_up_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_up_decode (
  input  wire logic                  up_clk,
  input  wire logic                  up_rstn,
  input  wire logic                  up_wreq,
  input  wire rx_reg_pkg::reg_addr_t up_waddr,
  input  wire logic [31:0]           up_wdata,
  input  wire logic                  up_rreq,
  input  wire rx_reg_pkg::reg_addr_t up_raddr,
  output rx_reg_pkg::up_access_t     access
);

  import rx_reg_pkg::*;

  localparam reg_addr_t ch0_base = chan_base;
  localparam reg_addr_t ch1_base = chan_base + chan_stride;

  reg_addr_t  addr;
  reg_addr_t  rel0;
  reg_addr_t  rel1;
  up_access_t next;

  // reads and writes never overlap, so one address path serves both
  assign addr = up_wreq ? up_waddr : up_raddr;

  // wraps on underflow, so below the base misses too
  assign rel0 = addr - ch0_base;
  assign rel1 = addr - ch1_base;

  // **************************************************
  // address decode
  // **************************************************

  always_comb begin
    next.wr     = up_wreq;
    next.rd     = up_rreq;
    next.wdata  = up_wdata;
    next.target = target_common;
    next.offset = com_unmapped_off;
    if (rel0 < chan_stride) begin
      next.target = target_ch0;
      next.offset = rel0[3:0];
    end else if (rel1 < chan_stride) begin
      next.target = target_ch1;
      next.offset = rel1[3:0];
    end else begin
      // anything unmatched stays on the unmapped common offset
      case (addr)
        addr_version: next.offset = com_version_off;
        addr_id:      next.offset = com_id_off;
        addr_scratch: next.offset = com_scratch_off;
        addr_status:  next.offset = com_status_off;
        default:      next.offset = com_unmapped_off;
      endcase
    end
  end

  // **************************************************
  // access register
  // **************************************************

  // one struct per request, visible to all blocks a cycle later
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      access <= '0;
    end else begin
      access <= next;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rx_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_channel #(
  parameter int chan_num = 0
) (
  input  wire logic                   up_clk,
  input  wire logic                   up_rstn,
  input  wire rx_reg_pkg::up_access_t access,
  input  wire logic                   adc_valid,
  input  wire rx_data_pkg::adc_raw_t  adc_data,
  output rx_data_pkg::chan_out_t      chan_out,
  output logic                        over_range,
  output logic [31:0]                 ch_rdata,
  output logic                        ch_ack
);

  import rx_reg_pkg::*;
  import rx_data_pkg::*;

  localparam access_target_e my_target = (chan_num == 0) ? target_ch0 : target_ch1;
  localparam int frac_bits = 14;
  localparam logic signed [2*out_width-1:0] sat_hi = 32'sd32767;
  localparam logic signed [2*out_width-1:0] sat_lo = -32'sd32768;

  logic                          hit;
  chan_ctrl_t                    ctrl_q;
  chan_scale_t                   scale_q;
  logic [adc_width-1:0]          raw;
  logic                          valid_s1;
  logic signed [out_width-1:0]   fmt_q;
  logic signed [2*out_width-1:0] product;
  logic signed [2*out_width-1:0] shifted;
  logic signed [out_width-1:0]   scaled;
  logic                          valid_q;
  logic [out_width-1:0]          data_q;

  assign hit = (access.target == my_target);

  // **************************************************
  // register access
  // **************************************************

  // the write word is read as a control or scale view by offset
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      ctrl_q   <= '0;
      scale_q  <= '{pad: '0, coef: 16'sh4000};
      ch_rdata <= '0;
      ch_ack   <= 1'b0;
    end else begin
      ch_ack   <= hit & (access.wr | access.rd);
      ch_rdata <= '0;
      if (hit && access.wr) begin
        case (access.offset)
          chan_ctrl_off: begin
            ctrl_q <= '{pad: '0,
                        scale_en: access.wdata.ctrl.scale_en,
                        format_en: access.wdata.ctrl.format_en,
                        enable: access.wdata.ctrl.enable};
          end
          chan_scale_off: scale_q <= '{pad: '0, coef: access.wdata.scale.coef};
          default: ;
        endcase
      end
      if (hit && access.rd) begin
        case (access.offset)
          chan_ctrl_off:  ch_rdata <= ctrl_q;
          chan_scale_off: ch_rdata <= scale_q;
          default:        ch_rdata <= '0;
        endcase
      end
    end
  end

  // **************************************************
  // stage one, format
  // **************************************************

  assign raw = (chan_num == 0) ? adc_data.i : adc_data.q;

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      valid_s1   <= 1'b0;
      over_range <= 1'b0;
    end else begin
      valid_s1   <= adc_valid;
      over_range <= adc_valid & ((raw == '0) | (raw == '1));
    end
  end

  // offset binary to two's complement flips the msb
  always_ff @(posedge up_clk) begin
    if (ctrl_q.format_en) begin
      fmt_q <= {{(out_width-adc_width+1){~raw[adc_width-1]}}, raw[adc_width-2:0]};
    end else begin
      fmt_q <= {{(out_width-adc_width){1'b0}}, raw};
    end
  end

  // **************************************************
  // stage two, scale and saturate
  // **************************************************

  always_comb begin
    product = $signed(scale_q.coef) * fmt_q;
    shifted = product >>> frac_bits;
    if (!ctrl_q.scale_en) begin
      scaled = fmt_q;
    end else if (shifted > sat_hi) begin
      scaled = sat_hi[out_width-1:0];
    end else if (shifted < sat_lo) begin
      scaled = sat_lo[out_width-1:0];
    end else begin
      scaled = shifted[out_width-1:0];
    end
  end

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_s1 & ctrl_q.enable;
    end
  end

  always_ff @(posedge up_clk) begin
    data_q <= scaled;
  end

  assign chan_out = '{enable: ctrl_q.enable, valid: valid_q, data: data_q};

endmodule

`default_nettype wire

// ==== verilog/rx_up_result.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_up_result #(
  parameter logic [31:0] ID = 32'h0
) (
  input  wire logic                   up_clk,
  input  wire logic                   up_rstn,
  input  wire rx_reg_pkg::up_access_t access,
  input  wire logic [31:0]            ch_rdata0,
  input  wire logic [31:0]            ch_rdata1,
  input  wire logic                   ch_ack0,
  input  wire logic                   ch_ack1,
  input  wire logic                   over_range0,
  input  wire logic                   over_range1,
  output logic [31:0]                 up_rdata,
  output logic                        up_wack,
  output logic                        up_rack
);

  import rx_reg_pkg::*;

  logic        hit;
  logic [31:0] wword;
  logic [1:0]  set;
  logic [1:0]  clr;
  logic [31:0] scratch_q;
  logic [1:0]  status_q;
  logic [31:0] rdata_q;
  logic        ack_q;
  logic        rd_q;
  logic        wr_q;
  logic        ack_any;

  assign hit   = (access.target == target_common);
  assign wword = access.wdata;
  assign set   = {over_range1, over_range0};
  assign clr   = (hit && access.wr && access.offset == com_status_off) ? wword[1:0] : 2'b00;

  // **************************************************
  // common registers
  // **************************************************

  // a new over-range pulse beats a clear in the same cycle
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      scratch_q <= '0;
      status_q  <= '0;
      rdata_q   <= '0;
      ack_q     <= 1'b0;
      rd_q      <= 1'b0;
      wr_q      <= 1'b0;
    end else begin
      status_q <= (status_q & ~clr) | set;
      ack_q    <= hit & (access.wr | access.rd);
      rd_q     <= access.rd;
      wr_q     <= access.wr;
      if (hit && access.wr && access.offset == com_scratch_off) begin
        scratch_q <= wword;
      end
      rdata_q <= '0;
      if (hit && access.rd) begin
        case (access.offset)
          com_version_off: rdata_q <= version_value;
          com_id_off:      rdata_q <= ID;
          com_scratch_off: rdata_q <= scratch_q;
          com_status_off:  rdata_q <= {30'd0, status_q};
          default:         rdata_q <= '0;
        endcase
      end
    end
  end

  // **************************************************
  // response merge
  // **************************************************

  assign ack_any = ack_q | ch_ack0 | ch_ack1;

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_rdata <= '0;
      up_wack  <= 1'b0;
      up_rack  <= 1'b0;
    end else begin
      up_rdata <= rdata_q | ch_rdata0 | ch_rdata1;
      up_wack  <= ack_any & wr_q;
      up_rack  <= ack_any & rd_q;
    end
  end

endmodule

`default_nettype wire

// ==== verilog/rx_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_core #(
  parameter logic [31:0] ID = 32'h0
) (
  input  wire logic                  up_clk,
  input  wire logic                  up_rstn,

  // adc interface
  input  wire logic                  adc_valid,
  input  wire logic [23:0]           adc_data,

  // dma interface
  output logic                       adc_enable_i,
  output logic                       adc_valid_i,
  output logic [15:0]                adc_data_i,
  output logic                       adc_enable_q,
  output logic                       adc_valid_q,
  output logic [15:0]                adc_data_q,

  // processor interface
  input  wire logic                  up_wreq,
  input  wire rx_reg_pkg::reg_addr_t up_waddr,
  input  wire logic [31:0]           up_wdata,
  output logic                       up_wack,
  input  wire logic                  up_rreq,
  input  wire rx_reg_pkg::reg_addr_t up_raddr,
  output logic [31:0]                up_rdata,
  output logic                       up_rack
);

  import rx_reg_pkg::*;
  import rx_data_pkg::*;

  up_access_t  access;
  chan_out_t   ch_out0;
  chan_out_t   ch_out1;
  logic [31:0] ch_rdata0;
  logic [31:0] ch_rdata1;
  logic        ch_ack0;
  logic        ch_ack1;
  logic        over_range0;
  logic        over_range1;

  // **************************************************
  // decode
  // **************************************************

  rx_up_decode i_up_decode (
    .up_clk   (up_clk),
    .up_rstn  (up_rstn),
    .up_wreq  (up_wreq),
    .up_waddr (up_waddr),
    .up_wdata (up_wdata),
    .up_rreq  (up_rreq),
    .up_raddr (up_raddr),
    .access   (access));

  // **************************************************
  // channels, 0 is i and 1 is q
  // **************************************************

  rx_channel #(.chan_num (0)) i_rx_channel_0 (
    .up_clk     (up_clk),
    .up_rstn    (up_rstn),
    .access     (access),
    .adc_valid  (adc_valid),
    .adc_data   (adc_data),
    .chan_out   (ch_out0),
    .over_range (over_range0),
    .ch_rdata   (ch_rdata0),
    .ch_ack     (ch_ack0));

  rx_channel #(.chan_num (1)) i_rx_channel_1 (
    .up_clk     (up_clk),
    .up_rstn    (up_rstn),
    .access     (access),
    .adc_valid  (adc_valid),
    .adc_data   (adc_data),
    .chan_out   (ch_out1),
    .over_range (over_range1),
    .ch_rdata   (ch_rdata1),
    .ch_ack     (ch_ack1));

  // **************************************************
  // common registers and response
  // **************************************************

  rx_up_result #(.ID (ID)) i_up_result (
    .up_clk      (up_clk),
    .up_rstn     (up_rstn),
    .access      (access),
    .ch_rdata0   (ch_rdata0),
    .ch_rdata1   (ch_rdata1),
    .ch_ack0     (ch_ack0),
    .ch_ack1     (ch_ack1),
    .over_range0 (over_range0),
    .over_range1 (over_range1),
    .up_rdata    (up_rdata),
    .up_wack     (up_wack),
    .up_rack     (up_rack));

  // dma side ports
  assign adc_enable_i = ch_out0.enable;
  assign adc_valid_i  = ch_out0.valid;
  assign adc_data_i   = ch_out0.data;
  assign adc_enable_q = ch_out1.enable;
  assign adc_valid_q  = ch_out1.valid;
  assign adc_data_q   = ch_out1.data;

endmodule

`default_nettype wire

// ==== dv/rx_core_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_core_chk (
  input wire logic up_clk,
  input wire logic up_rstn,
  input wire logic up_wreq,
  input wire logic up_rreq,
  input wire logic up_wack,
  input wire logic up_rack,
  input wire logic adc_valid,
  input wire logic adc_valid_i,
  input wire logic adc_enable_i
);

  // **************************************************
  // bus handshake
  // **************************************************

  // ack lands exactly three cycles after the request
  wr_ack_latency: assert property (@(posedge up_clk) disable iff (!up_rstn)
    up_wreq |-> ##1 !up_wack [*2] ##1 up_wack)
    else $error("write ack did not follow its request after 3 cycles");

  wr_ack_source: assert property (@(posedge up_clk) disable iff (!up_rstn)
    up_wack |-> $past(up_wreq, 3))
    else $error("write ack without a write request 3 cycles before");

  rd_ack_latency: assert property (@(posedge up_clk) disable iff (!up_rstn)
    up_rreq |-> ##1 !up_rack [*2] ##1 up_rack)
    else $error("read ack did not follow its request after 3 cycles");

  rd_ack_source: assert property (@(posedge up_clk) disable iff (!up_rstn)
    up_rack |-> $past(up_rreq, 3))
    else $error("read ack without a read request 3 cycles before");

  ack_exclusive: assert property (@(posedge up_clk) disable iff (!up_rstn)
    !(up_wack && up_rack))
    else $error("write and read ack high together");

  // **************************************************
  // sample pipeline
  // **************************************************

  valid_delay: assert property (@(posedge up_clk) disable iff (!up_rstn)
    adc_valid_i == ($past(adc_enable_i) && $past(adc_valid, 2)))
    else $error("channel i valid is not adc_valid delayed by 2 cycles");

endmodule

bind rx_core rx_core_chk i_rx_core_chk (.*);

`default_nettype wire

// ==== dv/rx_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_core_tb;

  localparam logic [31:0] core_id = 32'h52580001;
  localparam logic [31:0] lfsr_taps = 32'hd0000001;
  localparam int sample_count = 132;
  localparam int access_count = 37;
  localparam int cycle_limit = (sample_count + access_count) * 4 + 200;

  logic        up_clk;
  logic        up_rstn;
  logic        adc_valid;
  logic [23:0] adc_data;
  logic        up_wreq;
  logic [13:0] up_waddr;
  logic [31:0] up_wdata;
  logic        up_rreq;
  logic [13:0] up_raddr;
  wire         adc_enable_i;
  wire         adc_valid_i;
  wire  [15:0] adc_data_i;
  wire         adc_enable_q;
  wire         adc_valid_q;
  wire  [15:0] adc_data_q;
  wire         up_wack;
  wire  [31:0] up_rdata;
  wire         up_rack;

  logic [31:0] lfsr = 32'h3fef8ee3;
  logic [15:0] exp_q0[$];
  logic [15:0] exp_q1[$];
  logic [2:0]  ctrl_sh[2];
  logic [15:0] coef_sh[2];
  int          cycles = 0;
  int          checks = 0;
  int          total_errors = 0;
  int          test_errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  rx_core #(.ID (core_id)) i_rx_core (.*);

  initial begin
    up_clk = 1'b0;
    forever #10 up_clk = ~up_clk;
  end

  // **************************************************
  // helpers
  // **************************************************

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int k = 0; k < n; k++) begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ lfsr_taps) : (lfsr >> 1);
    end
    return v;
  endfunction

  // ctrl bits are {scale_en, format_en, enable}
  function automatic logic [15:0] expected_sample(input logic [11:0] raw,
                                                  input logic [2:0] ctrl,
                                                  input logic [15:0] coef);
    logic [11:0] tc;
    logic [15:0] v;
    longint      p;
    if (ctrl[1]) begin
      tc = {~raw[11], raw[10:0]};
      v  = {{4{tc[11]}}, tc};
    end else begin
      v = {4'h0, raw};
    end
    if (!ctrl[2]) return v;
    // Q2.14 product, floor shift, then clamp
    p = longint'($signed(coef)) * longint'($signed(v));
    p = p >>> 14;
    if (p > 32767) return 16'h7fff;
    if (p < -32768) return 16'h8000;
    return p[15:0];
  endfunction

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("error at %0t ns: %s got %h expected %h", $time, what, got, exp);
      total_errors++;
      test_errors++;
    end
  endtask

  task automatic bus_write(input logic [13:0] addr, input logic [31:0] data);
    @(posedge up_clk);
    up_wreq  <= 1'b1;
    up_waddr <= addr;
    up_wdata <= data;
    @(posedge up_clk);
    up_wreq <= 1'b0;
    while (!up_wack) @(posedge up_clk);
  endtask

  task automatic bus_read(input logic [13:0] addr, input logic [31:0] exp, input string what);
    @(posedge up_clk);
    up_rreq  <= 1'b1;
    up_raddr <= addr;
    @(posedge up_clk);
    up_rreq <= 1'b0;
    while (!up_rack) @(posedge up_clk);
    check(what, up_rdata, exp);
  endtask

  task automatic set_channel(input int ch, input logic [2:0] ctrl, input logic [15:0] coef);
    bus_write(14'h100 + 14'(ch * 16), {29'd0, ctrl});
    bus_write(14'h101 + 14'(ch * 16), {16'd0, coef});
    ctrl_sh[ch] = ctrl;
    coef_sh[ch] = coef;
  endtask

  task automatic send_sample(input logic [11:0] i_raw, input logic [11:0] q_raw);
    @(posedge up_clk);
    adc_valid <= 1'b1;
    adc_data  <= {q_raw, i_raw};
    if (ctrl_sh[0][0]) exp_q0.push_back(expected_sample(i_raw, ctrl_sh[0], coef_sh[0]));
    if (ctrl_sh[1][0]) exp_q1.push_back(expected_sample(q_raw, ctrl_sh[1], coef_sh[1]));
    // random idle cycle between samples
    if (take_bits(2) == 0) begin
      @(posedge up_clk);
      adc_valid <= 1'b0;
    end
  endtask

  task automatic send_random(input int n);
    logic [11:0] i_raw;
    logic [11:0] q_raw;
    repeat (n) begin
      i_raw = 12'(take_bits(12));
      q_raw = 12'(take_bits(12));
      send_sample(i_raw, q_raw);
    end
  endtask

  task automatic drain();
    @(posedge up_clk);
    adc_valid <= 1'b0;
    while (exp_q0.size() != 0 || exp_q1.size() != 0) @(posedge up_clk);
    repeat (3) @(posedge up_clk);
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      $display("test %0d %s: failed with %0d errors", tests_run, name, test_errors);
      tests_failed++;
    end
    test_errors = 0;
  endtask

  // **************************************************
  // compare and watchdog
  // **************************************************

  always @(posedge up_clk) begin
    if (up_rstn && adc_valid_i) begin
      if (exp_q0.size() == 0) begin
        $display("error at %0t ns: channel i gave a sample that was not expected", $time);
        total_errors++;
        test_errors++;
      end else begin
        check("channel i data", adc_data_i, exp_q0.pop_front());
      end
    end
    if (up_rstn && adc_valid_q) begin
      if (exp_q1.size() == 0) begin
        $display("error at %0t ns: channel q gave a sample that was not expected", $time);
        total_errors++;
        test_errors++;
      end else begin
        check("channel q data", adc_data_q, exp_q1.pop_front());
      end
    end
  end

  always @(posedge up_clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Test failures found");
      $finish;
    end
  end

  // **************************************************
  // test sequence
  // **************************************************

  initial begin
    logic [31:0] word;
    logic [15:0] c0;
    logic [15:0] c1;
    up_rstn   = 1'b0;
    adc_valid = 1'b0;
    adc_data  = '0;
    up_wreq   = 1'b0;
    up_waddr  = '0;
    up_wdata  = '0;
    up_rreq   = 1'b0;
    up_raddr  = '0;
    ctrl_sh   = '{3'b000, 3'b000};
    coef_sh   = '{16'h4000, 16'h4000};
    repeat (10) @(posedge up_clk);
    up_rstn <= 1'b1;

    bus_read(14'h000, 32'h00010000, "version");
    bus_read(14'h001, core_id, "id");
    word = take_bits(32);
    bus_write(14'h002, word);
    bus_read(14'h002, word, "scratch");
    bus_read(14'h3ff, 32'h0, "unmapped");
    bus_read(14'h100, 32'h0, "ch0 ctrl reset");
    bus_read(14'h101, 32'h4000, "ch0 scale reset");
    bus_read(14'h110, 32'h0, "ch1 ctrl reset");
    bus_read(14'h111, 32'h4000, "ch1 scale reset");
    end_test("registers");

    set_channel(0, 3'b001, 16'h4000);
    set_channel(1, 3'b001, 16'h4000);
    send_random(32);
    drain();
    end_test("zero extend");

    set_channel(0, 3'b011, 16'h4000);
    set_channel(1, 3'b011, 16'h4000);
    send_sample(12'h000, 12'hfff);
    send_sample(12'h800, 12'h000);
    send_sample(12'hfff, 12'h800);
    send_random(32);
    drain();
    end_test("format");

    // unity, large positive, most negative, then random coefficients
    for (int r = 0; r < 3; r++) begin
      case (r)
        0: begin
          c0 = 16'h4000;
          c1 = 16'h7fff;
        end
        1: begin
          c0 = 16'h8000;
          c1 = 16'(take_bits(16));
        end
        default: begin
          c0 = 16'(take_bits(16));
          c1 = 16'(take_bits(16));
        end
      endcase
      set_channel(0, 3'b111, c0);
      set_channel(1, 3'b111, c1);
      send_random(16);
      drain();
    end
    end_test("scale");

    bus_write(14'h010, 32'h3);
    send_sample(12'hfff, 12'h7a5);
    drain();
    bus_read(14'h010, 32'h1, "status set");
    bus_write(14'h010, 32'h1);
    bus_read(14'h010, 32'h0, "status cleared");
    end_test("over range");

    set_channel(0, 3'b001, 16'h4000);
    set_channel(1, 3'b000, 16'h4000);
    check("enable i", adc_enable_i, 1'b1);
    check("enable q", adc_enable_q, 1'b0);
    send_random(16);
    drain();
    end_test("disable");

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, total_errors);
    if (total_errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== build.f ====
verilog/rx_reg_pkg.sv
verilog/rx_data_pkg.sv
verilog/rx_up_decode.sv
verilog/rx_channel.sv
verilog/rx_up_result.sv
verilog/rx_core.sv
dv/rx_core_chk.sv
dv/rx_core_tb.sv

// ==== Bender.yml ====
package:
  name: rx_core

sources:
  # packages first, then rtl bottom up
  - verilog/rx_reg_pkg.sv
  - verilog/rx_data_pkg.sv
  - verilog/rx_up_decode.sv
  - verilog/rx_channel.sv
  - verilog/rx_up_result.sv
  - verilog/rx_core.sv

  - target: simulation
    files:
      - dv/rx_core_chk.sv
      - dv/rx_core_tb.sv
